//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert --timing -Ilogic
TOP      = rob_subsys_tb
FILELIST = rob_subsys.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

//--- logic/arch_map.sv
// architectural map
// committed logical to physical mapping, updated at retire

`timescale 1ns/10ps
`include "rob_defines.svh"

module arch_map import rob_pkg::*; (
	input  logic					clk,
	input  logic					rst,
	input  retire_t					retire_i,
	input  logic [`ARCH_IDX_W-1:0]	rd_idx_i,
	output logic [`PRF_IDX_W-1:0]	rd_tag_o
);
	localparam int NREG = 1 << `ARCH_IDX_W;

	logic [`PRF_IDX_W-1:0]	map_r [NREG];

	assign rd_tag_o = map_r[rd_idx_i];	// inspection port

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREG; i++) begin
				map_r[i] <= `PRF_IDX_W'(i);
			end
		end else if (retire_i.valid) begin
			map_r[retire_i.logic_dest] <= retire_i.dest_tag;
		end
	end

endmodule

//--- logic/free_list.sv
// free list of physical tags
// circular buffer, pops at dispatch, pushes old tags at retire, head rollback on mispredict

`timescale 1ns/10ps
`include "rob_defines.svh"

module free_list import rob_pkg::*; (
	input  logic					clk,
	input  logic					rst,
	input  logic					dispatch_ok_i,
	input  retire_t					retire_i,
	input  recovery_t				recovery_i,
	output logic [`PRF_IDX_W-1:0]	head_tag_o,
	output logic [`FL_W-1:0]		head_idx_o
);
	localparam int DEPTH = 1 << `FL_W;

	logic [`PRF_IDX_W-1:0]	tag_r [DEPTH];
	logic [`FL_W-1:0]		head_r;
	logic [`FL_W-1:0]		tail_r;
	logic [`FL_W-1:0]		tail_nxt;
	logic [`FL_W:0]			count_r;		// free tags held
	logic [`FL_W:0]			count_nxt;
	logic					empty;
	logic					rollback;

	assign rollback   = recovery_i.state == BR_PR_WRONG;
	assign empty      = count_r == '0;
	assign tail_nxt   = tail_r + retire_i.valid;
	assign head_idx_o = head_r;

	// the list runs dry only when the rob is full, then the retiring tag is reused at once
	assign head_tag_o = (empty && retire_i.valid) ? retire_i.old_tag : tag_r[head_r];

	always_comb begin
		if (rollback) begin
			// rob still holds the branch, so equal pointers mean empty
			count_nxt = {1'b0, tail_nxt - recovery_i.fl_head};
		end else begin
			case ({retire_i.valid, dispatch_ok_i})
				2'b10:   count_nxt = count_r + 1'b1;
				2'b01:   count_nxt = count_r - 1'b1;
				default: count_nxt = count_r;	// both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				tag_r[i] <= `PRF_IDX_W'(DEPTH + i);	// tags 0..31 are the arch state
			end
			head_r  <= '0;
			tail_r  <= '0;
			count_r <= {1'b1, {`FL_W{1'b0}}};
		end else begin
			if (retire_i.valid) begin
				tag_r[tail_r] <= retire_i.old_tag;
			end
			if (rollback) begin
				head_r <= recovery_i.fl_head;	// squashed tags become free again
			end else if (dispatch_ok_i) begin
				head_r <= head_r + 1'b1;
			end
			tail_r  <= tail_nxt;
			count_r <= count_nxt;
		end
	end

endmodule

//--- logic/map_table.sv
// speculative map table
// renames logical destinations, keeps one map copy per live branch checkpoint

`timescale 1ns/10ps
`include "rob_defines.svh"

module map_table import rob_pkg::*; (
	input  logic					clk,
	input  logic					rst,
	input  logic					dispatch_ok_i,
	input  dispatch_t				dispatch_i,
	input  logic [`PRF_IDX_W-1:0]	alloc_tag_i,
	input  recovery_t				recovery_i,
	output logic [`PRF_IDX_W-1:0]	old_tag_o,
	output logic [`BR_MASK_W-1:0]	br_slot_o,
	output logic [`BR_MASK_W-1:0]	live_mask_o,
	output logic					br_full_o
);
	localparam int NREG = 1 << `ARCH_IDX_W;

	logic [`PRF_IDX_W-1:0]	map_r [NREG];
	logic [`PRF_IDX_W-1:0]	map_nxt [NREG];
	logic [`PRF_IDX_W-1:0]	ckpt_r [`BR_MASK_W][NREG];
	logic [`BR_MASK_W-1:0]	live_r;
	logic [`BR_MASK_W-1:0]	live_nxt;
	logic [`BR_MASK_W-1:0]	slot_oh;
	logic					take_ckpt;
	logic					restore;

	assign old_tag_o   = map_r[dispatch_i.logic_dest];
	assign br_slot_o   = slot_oh;
	assign live_mask_o = live_r;
	assign br_full_o   = &live_r;
	assign take_ckpt   = dispatch_ok_i & dispatch_i.br_flag;
	assign restore     = recovery_i.state == BR_PR_WRONG;

	// lowest free checkpoint, zero when all are live
	always_comb begin
		slot_oh = '0;
		for (int i = `BR_MASK_W-1; i >= 0; i--) begin
			if (!live_r[i]) begin
				slot_oh = `BR_MASK_W'(1) << i;
			end
		end
	end

	// --------------------
	// next map and checkpoint state

	always_comb begin
		map_nxt = map_r;
		if (restore) begin
			for (int s = 0; s < `BR_MASK_W; s++) begin
				if (recovery_i.slot[s]) begin
					map_nxt = ckpt_r[s];
				end
			end
		end else if (dispatch_ok_i) begin
			map_nxt[dispatch_i.logic_dest] = alloc_tag_i;
		end
	end

	always_comb begin
		case (recovery_i.state)
			BR_PR_WRONG: live_nxt = recovery_i.keep_mask;		// drops itself and younger
			BR_PR_RIGHT: live_nxt = live_r & ~recovery_i.slot;
			default:     live_nxt = live_r;
		endcase
		if (take_ckpt) begin
			live_nxt = live_nxt | slot_oh;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NREG; i++) begin
				map_r[i] <= `PRF_IDX_W'(i);	// identity mapping
			end
			live_r <= '0;
		end else begin
			map_r  <= map_nxt;
			live_r <= live_nxt;
		end
	end

	// copy includes the branch's own rename
	always_ff @(posedge clk) begin
		for (int s = 0; s < `BR_MASK_W; s++) begin
			if (take_ckpt && slot_oh[s]) begin
				ckpt_r[s] <= map_nxt;
			end
		end
	end

endmodule

//--- logic/rob.sv
// reorder buffer
// 32 entries, dispatch at tail, completion marks done, in-order retire at head
// branch resolution drives early recovery of the tail, free list and map table

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob import rob_pkg::*; (
	input  logic					clk,
	input  logic					rst,
	input  logic					dispatch_i,
	input  dispatch_t				dispatch_data_i,
	input  logic [`PRF_IDX_W-1:0]	alloc_tag_i,	// free list head tag
	input  logic [`PRF_IDX_W-1:0]	old_tag_i,		// previous mapping of the dest
	input  logic [`FL_W-1:0]		fl_head_i,
	input  logic [`BR_MASK_W-1:0]	br_slot_i,
	input  logic [`BR_MASK_W-1:0]	live_mask_i,
	input  logic					br_full_i,
	input  complete_t				complete_i,
	output logic					dispatch_ok_o,
	output logic [`HT_W-1:0]		rob_idx_o,
	output logic					stall_o,
	output retire_t					retire_o,
	output recovery_t				recovery_o
);
	typedef struct packed {
		logic [`PRF_IDX_W-1:0]	dest_tag;
		logic [`PRF_IDX_W-1:0]	old_tag;
		logic [`ARCH_IDX_W-1:0]	logic_dest;
		logic [`ADDR_W-1:0]		npc;
		logic					br_flag;
		logic					br_pretaken;
		logic [`ADDR_W-1:0]		br_target;
		logic					rd_mem;
		logic					wr_mem;
		logic [`FL_W-1:0]		fl_head;
		logic [`BR_MASK_W-1:0]	br_slot;
	} rob_entry_t;

	localparam rob_entry_t CLR_ENTRY = '{logic_dest: `ZERO_REG, default: '0};

	logic [`HT_W:0]			head_r;
	logic [`HT_W:0]			tail_r;
	logic [`HT_W:0]			tail_rec;
	logic [`HT_W-1:0]		head_idx;
	logic [`HT_W-1:0]		tail_idx;
	logic [`HT_W-1:0]		br_dist;
	rob_entry_t				entry_r [`ROB_W];
	logic [`BR_MASK_W-1:0]	mask_r [`ROB_W];	// older branches each entry depends on
	logic [`ROB_W-1:0]		done_r;
	rob_entry_t				new_entry;
	rob_entry_t				cpl_entry;
	logic [`BR_MASK_W-1:0]	clr_slot;
	logic [`FL_W-1:0]		fl_next_head;
	logic					full;
	logic					empty;
	logic					retire_rdy;
	logic					br_cpl;
	logic					mispredict;
	logic					wrong;

	assign head_idx   = head_r[`HT_W-1:0];
	assign tail_idx   = tail_r[`HT_W-1:0];
	assign full       = (head_r ^ tail_r) == {1'b1, {`HT_W{1'b0}}};
	assign empty      = head_r == tail_r;
	assign retire_rdy = done_r[head_idx] & ~empty;	// stale done bits past the tail are ignored

	// --------------------
	// branch resolution

	assign cpl_entry  = entry_r[complete_i.rob_idx];
	assign br_cpl     = complete_i.valid & cpl_entry.br_flag;
	assign mispredict = (cpl_entry.br_pretaken != complete_i.br_taken) ||
						(cpl_entry.br_target != complete_i.br_target);
	assign wrong      = br_cpl & mispredict;
	assign clr_slot   = (br_cpl && !mispredict) ? cpl_entry.br_slot : '0;

	always_comb begin
		recovery_o       = '0;
		recovery_o.state = BR_NONE;
		if (br_cpl) begin
			recovery_o.state     = mispredict ? BR_PR_WRONG : BR_PR_RIGHT;
			recovery_o.slot      = cpl_entry.br_slot;
			recovery_o.keep_mask = mask_r[complete_i.rob_idx];
			recovery_o.fl_head   = cpl_entry.fl_head;
		end
	end

	// new tail is just past the branch, measured from the head to keep the wrap bit right
	assign br_dist  = complete_i.rob_idx - head_idx;
	assign tail_rec = head_r + br_dist + 1'b1;

	// --------------------
	// dispatch

	assign dispatch_ok_o = dispatch_i && (!full || retire_rdy) &&
						   !(dispatch_data_i.br_flag && br_full_i) && !wrong;
	assign rob_idx_o     = tail_idx;
	assign stall_o       = (full & ~retire_rdy) | br_full_i;
	assign fl_next_head  = fl_head_i + 1'b1;	// head after this entry's own tag

	always_comb begin
		new_entry             = CLR_ENTRY;
		new_entry.dest_tag    = alloc_tag_i;
		new_entry.old_tag     = old_tag_i;
		new_entry.logic_dest  = dispatch_data_i.logic_dest;
		new_entry.npc         = dispatch_data_i.npc;
		new_entry.br_flag     = dispatch_data_i.br_flag;
		new_entry.br_pretaken = dispatch_data_i.br_pretaken;
		new_entry.br_target   = dispatch_data_i.br_target;
		new_entry.rd_mem      = dispatch_data_i.rd_mem;
		new_entry.wr_mem      = dispatch_data_i.wr_mem;
		new_entry.fl_head     = fl_next_head;
		new_entry.br_slot     = br_slot_i;
	end

	// --------------------
	// retire

	always_comb begin
		retire_o            = '0;
		retire_o.valid      = retire_rdy;
		retire_o.logic_dest = entry_r[head_idx].logic_dest;
		retire_o.dest_tag   = entry_r[head_idx].dest_tag;
		retire_o.old_tag    = entry_r[head_idx].old_tag;
		retire_o.rd_mem     = entry_r[head_idx].rd_mem;
		retire_o.wr_mem     = entry_r[head_idx].wr_mem;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			done_r <= '0;
		end else begin
			head_r <= head_r + retire_rdy;
			if (wrong) begin
				tail_r <= tail_rec;
			end else if (dispatch_ok_o) begin
				tail_r <= tail_r + 1'b1;
			end
			if (retire_rdy) begin
				done_r[head_idx] <= 1'b0;
			end
			if (dispatch_ok_o) begin
				done_r[tail_idx] <= 1'b0;
			end
			if (complete_i.valid) begin
				done_r[complete_i.rob_idx] <= 1'b1;
			end
		end
	end

	// on a full rob the retiring head and the new tail share a slot, dispatch wins
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ROB_W; i++) begin
				entry_r[i] <= CLR_ENTRY;
				mask_r[i]  <= '0;
			end
		end else begin
			for (int i = 0; i < `ROB_W; i++) begin
				mask_r[i] <= mask_r[i] & ~clr_slot;	// resolved branch frees its slot
			end
			if (retire_rdy) begin
				entry_r[head_idx] <= CLR_ENTRY;
				mask_r[head_idx]  <= '0;
			end
			if (dispatch_ok_o) begin
				entry_r[tail_idx] <= new_entry;
				mask_r[tail_idx]  <= live_mask_i & ~clr_slot;
			end
		end
	end

endmodule

//--- logic/rob_defines.svh
// rename and retire slice, shared widths and depths
// physical tags are 6 bits, logical registers 5 bits

`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

`define PRF_IDX_W	6		// physical tag width
`define ARCH_IDX_W	5		// logical register width
`define ROB_W		32		// reorder buffer entries
`define HT_W		5		// rob index, head and tail add a wrap bit
`define FL_W		5		// free list index, 32 free tags
`define BR_MASK_W	4		// branch checkpoints
`define ADDR_W		64		// pc and branch target width

// stored destination of an empty rob entry
`define ZERO_REG	5'd31

`endif

//--- logic/rob_pkg.sv
// rob subsystem types
// structs passed between decode, the functional units and the rename blocks

`include "rob_defines.svh"

package rob_pkg;

	// outcome of a completing instruction
	typedef enum logic [1:0] {
		BR_NONE     = 2'd0,		// not a branch, or no completion
		BR_PR_RIGHT = 2'd1,
		BR_PR_WRONG = 2'd2
	} br_state_e;

	// decoded instruction, 137 bits
	typedef struct packed {
		logic [`ARCH_IDX_W-1:0]	logic_dest;
		logic [`ADDR_W-1:0]		npc;
		logic					br_flag;
		logic					br_pretaken;
		logic [`ADDR_W-1:0]		br_target;	// predicted target
		logic					rd_mem;
		logic					wr_mem;
	} dispatch_t;

	// functional unit report
	typedef struct packed {
		logic					valid;
		logic [`HT_W-1:0]		rob_idx;
		logic					br_taken;
		logic [`ADDR_W-1:0]		br_target;	// resolved target
	} complete_t;

	typedef struct packed {
		logic					valid;
		logic [`ARCH_IDX_W-1:0]	logic_dest;
		logic [`PRF_IDX_W-1:0]	dest_tag;	// becomes the committed mapping
		logic [`PRF_IDX_W-1:0]	old_tag;	// goes back to the free list
		logic					rd_mem;
		logic					wr_mem;
	} retire_t;

	// branch resolution, broadcast in the completion cycle
	typedef struct packed {
		br_state_e				state;
		logic [`BR_MASK_W-1:0]	slot;		// one-hot checkpoint of the branch
		logic [`BR_MASK_W-1:0]	keep_mask;	// older branches still live
		logic [`FL_W-1:0]		fl_head;	// free list head just after the branch
	} recovery_t;

endpackage

//--- logic/rob_subsys_top.sv
// rename and retire slice top level
// free list, speculative map, reorder buffer and architectural map

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_subsys_top import rob_pkg::*; (
	input  logic					clk,
	input  logic					rst,
	// decode side
	input  logic					dispatch_i,
	input  dispatch_t				dispatch_data_i,
	output logic					dispatch_ok_o,
	output logic [`HT_W-1:0]		rob_idx_o,
	output logic [`PRF_IDX_W-1:0]	alloc_tag_o,
	output logic [`PRF_IDX_W-1:0]	old_tag_o,
	output logic					stall_o,
	// functional units
	input  complete_t				complete_i,
	output retire_t					retire_o,
	output recovery_t				recovery_o,
	// committed state read
	input  logic [`ARCH_IDX_W-1:0]	arch_rd_idx_i,
	output logic [`PRF_IDX_W-1:0]	arch_rd_tag_o
);
	logic [`FL_W-1:0]		fl_head_idx;
	logic [`BR_MASK_W-1:0]	br_slot;
	logic [`BR_MASK_W-1:0]	live_mask;
	logic					br_full;

	// --------------------
	// rename

	free_list u_free_list (
		.clk			(clk),
		.rst			(rst),
		.dispatch_ok_i	(dispatch_ok_o),
		.retire_i		(retire_o),
		.recovery_i		(recovery_o),
		.head_tag_o		(alloc_tag_o),
		.head_idx_o		(fl_head_idx)
	);

	map_table u_map_table (
		.clk			(clk),
		.rst			(rst),
		.dispatch_ok_i	(dispatch_ok_o),
		.dispatch_i		(dispatch_data_i),
		.alloc_tag_i	(alloc_tag_o),
		.recovery_i		(recovery_o),
		.old_tag_o		(old_tag_o),
		.br_slot_o		(br_slot),
		.live_mask_o	(live_mask),
		.br_full_o		(br_full)
	);

	// --------------------
	// ordering and commit

	rob u_rob (
		.clk			(clk),
		.rst			(rst),
		.dispatch_i		(dispatch_i),
		.dispatch_data_i(dispatch_data_i),
		.alloc_tag_i	(alloc_tag_o),
		.old_tag_i		(old_tag_o),
		.fl_head_i		(fl_head_idx),
		.br_slot_i		(br_slot),
		.live_mask_i	(live_mask),
		.br_full_i		(br_full),
		.complete_i		(complete_i),
		.dispatch_ok_o	(dispatch_ok_o),
		.rob_idx_o		(rob_idx_o),
		.stall_o		(stall_o),
		.retire_o		(retire_o),
		.recovery_o		(recovery_o)
	);

	arch_map u_arch_map (
		.clk			(clk),
		.rst			(rst),
		.retire_i		(retire_o),
		.rd_idx_i		(arch_rd_idx_i),
		.rd_tag_o		(arch_rd_tag_o)
	);

endmodule

//--- rob_subsys.f
+incdir+logic
logic/rob_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/rob.sv
logic/arch_map.sv
logic/rob_subsys_top.sv
test/rob_subsys_chk.sv
test/rob_subsys_tb.sv

//--- test/rob_subsys_chk.sv
// protocol checks on the rename and retire slice
// bound to the top level, watches dispatch, stall and recovery

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_subsys_chk import rob_pkg::*; (
	input  logic		clk,
	input  logic		rst,
	input  logic		dispatch_ok_o,
	input  logic		stall_o,
	input  logic		br_full,		// all checkpoints live
	input  logic		br_dispatch,	// offered instruction is a branch
	input  logic		complete_valid,
	input  retire_t		retire_o,
	input  recovery_t	recovery_o
);

	// a full rob without a retiring head takes nothing
	a_stall_blocks: assert property (@(posedge clk) disable iff (rst)
		(stall_o && !br_full) |-> !dispatch_ok_o)
		else $error("dispatch accepted while the rob is stalled");

	a_br_full_blocks: assert property (@(posedge clk) disable iff (rst)
		(br_full && br_dispatch) |-> !dispatch_ok_o)
		else $error("branch accepted with every checkpoint live");

	// recovery only comes from a completing branch
	a_recovery_cause: assert property (@(posedge clk) disable iff (rst)
		(recovery_o.state != BR_NONE) |-> complete_valid)
		else $error("recovery reported without a completion");

	a_wrong_blocks: assert property (@(posedge clk) disable iff (rst)
		(recovery_o.state == BR_PR_WRONG) |-> !dispatch_ok_o)
		else $error("dispatch accepted in a recovery cycle");

	a_reset_quiet: assert property (@(posedge clk)
		rst |=> (!retire_o.valid && recovery_o.state == BR_NONE))
		else $error("retire or recovery active right after reset");

endmodule

//--- test/rob_subsys_tb.sv
// testbench for the rename and retire slice
// plays the functional units, keeps a reference queue and rename model

`timescale 1ns/10ps
`include "rob_defines.svh"

module rob_subsys_tb import rob_pkg::*; ();
	localparam int STIM_CYCLES = 510;			// all phases together
	localparam int LIMIT       = 4 * STIM_CYCLES;

	typedef struct packed {
		logic [4:0]		idx;
		logic [5:0]		tag;
		logic [5:0]		old;
		logic [4:0]		dest;
		logic			br;
		logic			pt;
		logic [63:0]	tgt;
		logic [3:0]		slot;		// one-hot checkpoint of a branch
		logic [4:0]		fl;			// free list head just after this entry
		logic			rd;
		logic			wr;
		logic			done;
		logic			resolved;
	} ent_t;

	logic		clk;
	logic		rst;
	logic		dispatch_i;
	dispatch_t	dispatch_data_i;
	complete_t	complete_i;
	logic [4:0]	arch_rd_idx_i;
	logic		dispatch_ok_o;
	logic [4:0]	rob_idx_o;
	logic [5:0]	alloc_tag_o;
	logic [5:0]	old_tag_o;
	logic		stall_o;
	retire_t	retire_o;
	recovery_t	recovery_o;
	logic [5:0]	arch_rd_tag_o;

	ent_t		q[$];
	logic [5:0]	model_map [32];
	logic [5:0]	arch_model [32];
	logic [5:0]	ckpt [32][32];		// rename map after each branch by rob index
	logic [5:0]	first_after [32];	// first tag taken after each branch
	bit			first_valid [32];
	logic [3:0]	slot_live;			// checkpoints held by unresolved branches
	logic [4:0]	fl_idx;
	logic [4:0]	exp_tail;
	logic [5:0]	exp_alloc;
	bit			exp_alloc_valid;
	logic [4:0]	last_dest;
	logic [15:0] lfsr;
	int			errors;
	int			checks;
	int			cycles;
	int			p;

	rob_subsys_top DUT (.*);

	bind rob_subsys_top rob_subsys_chk u_chk (
		.clk(clk), .rst(rst), .dispatch_ok_o(dispatch_ok_o), .stall_o(stall_o),
		.br_full(br_full), .br_dispatch(dispatch_data_i.br_flag),
		.complete_valid(complete_i.valid), .retire_o(retire_o), .recovery_o(recovery_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout, run still going after %0d cycles", LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	// --------------------
	// stimulus helpers

	function bit lfsr_step();
		bit b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 16'hB400;
		return b;
	endfunction

	function int rand_bits(int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) r = (r << 1) | int'(lfsr_step());
		return r;
	endfunction

	// a new branch takes the free checkpoint with the lowest number
	function automatic logic [3:0] lowest_free(logic [3:0] held);
		for (int i = 0; i < 4; i++) begin
			if (!held[i]) return 4'(1 << i);
		end
		return 4'b0;
	endfunction

	task automatic check_eq(string name, int got, int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_true(string what, bit cond);
		checks++;
		assert (cond) else begin
			errors++;
			$display("at %0t: %s", $time, what);
		end
	endtask

	task automatic drive_idle();
		dispatch_i      = 1'b0;
		dispatch_data_i = '0;
		complete_i      = '0;
		arch_rd_idx_i   = last_dest;	// watch the latest committed register
	endtask

	task automatic drive_dispatch(bit br);
		dispatch_i                  = 1'b1;
		dispatch_data_i.logic_dest  = 5'(rand_bits(5));
		dispatch_data_i.npc         = 64'(rand_bits(16));
		dispatch_data_i.br_flag     = br;
		dispatch_data_i.br_pretaken = br ? lfsr_step() : 1'b0;
		dispatch_data_i.br_target   = br ? 64'(rand_bits(8)) : '0;
		dispatch_data_i.rd_mem      = lfsr_step();
		dispatch_data_i.wr_mem      = lfsr_step();
	endtask

	// flip makes a branch resolve against its prediction
	task automatic drive_complete(int pos, bit flip);
		ent_t e;
		bit ft;
		e  = q[pos];
		ft = lfsr_step();
		complete_i.valid     = 1'b1;
		complete_i.rob_idx   = e.idx;
		complete_i.br_taken  = e.br & (e.pt ^ (flip & ft));
		complete_i.br_target = e.br ? (e.tgt ^ 64'(flip & ~ft)) : '0;
	endtask

	function automatic int pick_pending();
		int list[$];
		for (int i = 0; i < q.size(); i++) if (!q[i].done) list.push_back(i);
		if (list.size() == 0) return -1;
		return list[rand_bits(5) % list.size()];
	endfunction

	// --------------------
	// per cycle check against the reference model

	task automatic check_cycle();
		int live;
		int cpos;
		bit head_done;
		bit ok_exp;
		bit in_map;
		br_state_e st_exp;
		logic [3:0] keep_exp;
		logic [3:0] live_before;
		ent_t e;
		live = 0;
		cpos = -1;
		st_exp = BR_NONE;
		keep_exp = '0;
		live_before = slot_live;
		foreach (q[i]) if (q[i].br && !q[i].resolved) live++;
		head_done = q.size() > 0 && q[0].done;
		if (complete_i.valid) begin
			foreach (q[i]) if (q[i].idx == complete_i.rob_idx) cpos = i;
		end
		if (cpos >= 0 && q[cpos].br) begin
			st_exp = (q[cpos].pt != complete_i.br_taken || q[cpos].tgt != complete_i.br_target) ?
				BR_PR_WRONG : BR_PR_RIGHT;
		end
		ok_exp = dispatch_i && (q.size() < 32 || head_done) &&
			!(dispatch_data_i.br_flag && live == 4) && st_exp != BR_PR_WRONG;
		check_eq("recovery_o.state", int'(recovery_o.state), int'(st_exp));
		check_eq("dispatch_ok_o", int'(dispatch_ok_o), int'(ok_exp));
		check_eq("stall_o", int'(stall_o), int'((q.size() == 32 && !head_done) || live == 4));
		check_eq("retire_o.valid", int'(retire_o.valid), int'(head_done));
		check_eq("arch_rd_tag_o", int'(arch_rd_tag_o), int'(arch_model[arch_rd_idx_i]));
		if (st_exp != BR_NONE) begin
			// older branches that are still unresolved keep their checkpoints
			for (int i = 0; i < cpos; i++) begin
				if (q[i].br && !q[i].resolved) keep_exp = keep_exp | q[i].slot;
			end
			check_eq("recovery_o.slot", int'(recovery_o.slot), int'(q[cpos].slot));
			check_eq("recovery_o.keep_mask", int'(recovery_o.keep_mask), int'(keep_exp));
			check_eq("recovery_o.fl_head", int'(recovery_o.fl_head), int'(q[cpos].fl));
		end
		if (retire_o.valid && head_done) begin
			check_eq("retire_o.logic_dest", int'(retire_o.logic_dest), int'(q[0].dest));
			check_eq("retire_o.dest_tag", int'(retire_o.dest_tag), int'(q[0].tag));
			check_eq("retire_o.old_tag", int'(retire_o.old_tag), int'(q[0].old));
			check_eq("retire_o.rd_mem", int'(retire_o.rd_mem), int'(q[0].rd));
			check_eq("retire_o.wr_mem", int'(retire_o.wr_mem), int'(q[0].wr));
			arch_model[q[0].dest] = q[0].tag;
			last_dest = q[0].dest;
			void'(q.pop_front());
			cpos--;
		end
		if (cpos >= 0) begin
			e = q[cpos];
			e.done = 1'b1;
			e.resolved = 1'b1;
			q[cpos] = e;
			if (st_exp == BR_PR_RIGHT) begin
				slot_live = slot_live & ~e.slot;
			end
			if (st_exp == BR_PR_WRONG) begin
				while (q.size() > cpos + 1) void'(q.pop_back());
				model_map = ckpt[e.idx];
				slot_live = keep_exp;
				fl_idx = e.fl;
				exp_tail = e.idx + 5'd1;
				exp_alloc = first_after[e.idx];
				exp_alloc_valid = first_valid[e.idx];
			end
		end
		if (dispatch_ok_o) begin
			in_map = 1'b0;
			foreach (model_map[i]) if (model_map[i] == alloc_tag_o) in_map = 1'b1;
			check_true("allocated tag is still mapped", !in_map);
			check_eq("rob_idx_o", int'(rob_idx_o), int'(exp_tail));
			check_eq("old_tag_o", int'(old_tag_o), int'(model_map[dispatch_data_i.logic_dest]));
			if (exp_alloc_valid) check_eq("alloc_tag_o", int'(alloc_tag_o), int'(exp_alloc));
			exp_alloc_valid = 1'b0;
			foreach (q[i]) begin
				if (q[i].br && !first_valid[q[i].idx]) begin
					first_after[q[i].idx] = alloc_tag_o;
					first_valid[q[i].idx] = 1'b1;
				end
			end
			fl_idx++;
			e = '{idx: exp_tail, tag: alloc_tag_o, old: old_tag_o,
				dest: dispatch_data_i.logic_dest, br: dispatch_data_i.br_flag,
				pt: dispatch_data_i.br_pretaken, tgt: dispatch_data_i.br_target,
				slot: dispatch_data_i.br_flag ? lowest_free(live_before) : 4'b0,
				fl: fl_idx, rd: dispatch_data_i.rd_mem, wr: dispatch_data_i.wr_mem,
				done: 1'b0, resolved: 1'b0};
			q.push_back(e);
			model_map[dispatch_data_i.logic_dest] = alloc_tag_o;
			if (e.br) begin
				ckpt[exp_tail] = model_map;
				first_valid[exp_tail] = 1'b0;
				slot_live = slot_live | e.slot;
			end
			exp_tail++;
		end
	endtask

	task automatic step();
		#1;
		check_cycle();
		@(negedge clk);
	endtask

	// --------------------
	// test sequence

	initial begin
		lfsr = 16'd49408;
		errors = 0;
		checks = 0;
		cycles = 0;
		slot_live = '0;
		fl_idx = '0;
		exp_tail = '0;
		exp_alloc = '0;
		exp_alloc_valid = 1'b0;
		last_dest = '0;
		for (int i = 0; i < 32; i++) begin
			model_map[i] = 6'(i);
			arch_model[i] = 6'(i);
			first_valid[i] = 1'b0;
		end
		rst = 1'b1;
		drive_idle();
		repeat (2) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 32; i++) begin	// reset state and identity arch map
			drive_idle();
			arch_rd_idx_i = 5'(i);
			step();
		end
		repeat (36) begin					// fill the rob until dispatch is refused
			drive_idle();
			drive_dispatch(1'b0);
			step();
		end
		while (q.size() > 0) begin
			drive_idle();
			p = pick_pending();
			if (p >= 0) drive_complete(p, 1'b0);
			step();
		end
		repeat (5) begin					// fifth branch finds no checkpoint
			drive_idle();
			drive_dispatch(1'b1);
			step();
		end
		drive_idle();
		drive_complete(0, 1'b0);
		step();
		drive_idle();
		drive_dispatch(1'b1);				// freed slot is taken again
		step();
		repeat (3) begin
			drive_idle();
			drive_dispatch(1'b0);
			step();
		end
		p = -1;
		for (int i = q.size() - 1; i >= 0; i--) if (q[i].br && !q[i].done) p = i;
		drive_idle();
		drive_complete(p, 1'b1);
		step();
		drive_idle();
		drive_dispatch(1'b0);
		step();
		repeat (300) begin					// random mix
			drive_idle();
			if (rand_bits(2) != 0) drive_dispatch(rand_bits(2) == 0);
			if (lfsr_step()) begin
				p = pick_pending();
				if (p >= 0) drive_complete(p, rand_bits(2) == 0);
			end
			step();
		end
		while (q.size() > 0) begin
			drive_idle();
			p = pick_pending();
			if (p >= 0) drive_complete(p, 1'b0);
			step();
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
